/* common/core_pkg.sv */
package core_pkg;

    localparam int          XLEN     = 32;            // Data width
    localparam logic [31:0] RESET_PC = 32'h0000_0000; // PC after reset
    localparam logic [31:0] NOP_INST = 32'h0000_0013; // ADDI x0,x0,0

    typedef logic [31:0] inst_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    typedef enum logic [1:0] {
        A_SEL_REG  = 2'b00,
        A_SEL_PC   = 2'b01,
        A_SEL_ZERO = 2'b10
    } data_a_sel_e;

    typedef enum logic [1:0] {
        B_SEL_REG  = 2'b00,
        B_SEL_IMM  = 2'b01,
        B_SEL_FOUR = 2'b10
    } data_b_sel_e;

    typedef enum logic {
        WR_SEL_CALC = 1'b0,
        WR_SEL_LOAD = 1'b1
    } wr_data_sel_e;

    // Same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        ACCESS_BYTE = 2'b00,
        ACCESS_HALF = 2'b01,
        ACCESS_WORD = 2'b10
    } data_access_e;

    typedef enum logic [1:0] {
        PC_PLUS4    = 2'b00,
        PC_OFFSET   = 2'b01,
        PC_INDIRECT = 2'b11
    } pc_next_sel_e;

    typedef struct packed {
        alu_op_e      alu_op;
        data_a_sel_e  a_sel;
        data_b_sel_e  b_sel;
        wr_data_sel_e wr_data_sel;
        logic         reg_wr_en;
        logic         mem_rd_en;
        logic         mem_wr_en;
        data_access_e mem_access;
        logic         mem_unsigned;
        pc_next_sel_e pc_next_sel;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;    // Word aligned
        logic [XLEN-1:0] wdata;
        logic [3:0]      byte_en;
        logic            wr_en;
        logic            rd_en;
    } dmem_req_t;

endpackage

/* design/datapath_controller.sv */
`timescale 1ns/10ps

module datapath_controller
    import core_pkg::*;
(
    input  inst_t i_inst,             // Current instruction
    input  logic  i_is_equal,         // rs1 == rs2
    input  logic  i_is_less_signed,   // rs1 < rs2 signed
    input  logic  i_is_less_unsigned, // rs1 < rs2 unsigned
    output ctrl_t o_ctrl
);

    logic [2:0] funct3;
    logic       funct7_5;
    logic       taken;

    assign funct3   = i_inst[14:12];
    assign funct7_5 = i_inst[30];

    // Branch condition from funct3
    always_comb
    begin
        case (funct3)
            3'b000:  taken = i_is_equal;          // BEQ
            3'b001:  taken = !i_is_equal;         // BNE
            3'b100:  taken = i_is_less_signed;    // BLT
            3'b101:  taken = !i_is_less_signed;   // BGE
            3'b110:  taken = i_is_less_unsigned;  // BLTU
            3'b111:  taken = !i_is_less_unsigned; // BGEU
            default: taken = 1'b0;
        endcase
    end

    always_comb
    begin
        o_ctrl.alu_op       = ALU_ADD;
        o_ctrl.a_sel        = A_SEL_REG;
        o_ctrl.b_sel        = B_SEL_REG;
        o_ctrl.wr_data_sel  = WR_SEL_CALC;
        o_ctrl.reg_wr_en    = 1'b0;
        o_ctrl.mem_rd_en    = 1'b0;
        o_ctrl.mem_wr_en    = 1'b0;
        o_ctrl.mem_access   = ACCESS_WORD;
        o_ctrl.mem_unsigned = 1'b0;
        o_ctrl.pc_next_sel  = PC_PLUS4;

        case (opcode_e'(i_inst[6:0]))
            OPC_LUI:
            begin
                o_ctrl.a_sel     = A_SEL_ZERO; // 0 + imm
                o_ctrl.b_sel     = B_SEL_IMM;
                o_ctrl.reg_wr_en = 1'b1;
            end
            OPC_AUIPC:
            begin
                o_ctrl.a_sel     = A_SEL_PC;
                o_ctrl.b_sel     = B_SEL_IMM;
                o_ctrl.reg_wr_en = 1'b1;
            end
            OPC_JAL:
            begin
                o_ctrl.a_sel       = A_SEL_PC; // Link is PC + 4
                o_ctrl.b_sel       = B_SEL_FOUR;
                o_ctrl.reg_wr_en   = 1'b1;
                o_ctrl.pc_next_sel = PC_OFFSET;
            end
            OPC_JALR:
            begin
                if (funct3 == 3'b000)
                begin
                    o_ctrl.a_sel       = A_SEL_PC;
                    o_ctrl.b_sel       = B_SEL_FOUR;
                    o_ctrl.reg_wr_en   = 1'b1;
                    o_ctrl.pc_next_sel = PC_INDIRECT;
                end
            end
            OPC_BRANCH:
            begin
                if (taken)
                    o_ctrl.pc_next_sel = PC_OFFSET;
            end
            OPC_LOAD:
            begin
                // LB LH LW LBU LHU only
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11)
                begin
                    o_ctrl.b_sel        = B_SEL_IMM;
                    o_ctrl.wr_data_sel  = WR_SEL_LOAD;
                    o_ctrl.reg_wr_en    = 1'b1;
                    o_ctrl.mem_rd_en    = 1'b1;
                    o_ctrl.mem_access   = data_access_e'(funct3[1:0]);
                    o_ctrl.mem_unsigned = funct3[2];
                end
            end
            OPC_STORE:
            begin
                if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) // SB SH SW
                begin
                    o_ctrl.b_sel      = B_SEL_IMM;
                    o_ctrl.mem_wr_en  = 1'b1;
                    o_ctrl.mem_access = data_access_e'(funct3[1:0]);
                end
            end
            OPC_OP_IMM:
            begin
                o_ctrl.b_sel     = B_SEL_IMM;
                o_ctrl.reg_wr_en = 1'b1;
                // funct7 only matters for SRLI/SRAI
                o_ctrl.alu_op    = alu_op_e'({(funct3 == 3'b101) & funct7_5, funct3});
            end
            OPC_OP:
            begin
                if (i_inst[31:25] == 7'b0000000 ||
                    (i_inst[31:25] == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
                begin
                    o_ctrl.reg_wr_en = 1'b1;
                    o_ctrl.alu_op    = alu_op_e'({funct7_5, funct3});
                end
            end
            default: ; // Unknown opcode is a no-op
        endcase
    end

endmodule

/* design/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit
    import core_pkg::*;
(
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_pc,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_rs2_data,
    input  logic [XLEN-1:0] i_imm,
    output logic [XLEN-1:0] o_result,
    output logic            o_is_equal,
    output logic            o_is_less_signed,
    output logic            o_is_less_unsigned
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    always_comb
    begin
        case (i_ctrl.a_sel)
            A_SEL_PC:   op_a = i_pc;
            A_SEL_ZERO: op_a = '0;
            default:    op_a = i_rs1_data;
        endcase
        case (i_ctrl.b_sel)
            B_SEL_IMM:  op_b = i_imm;
            B_SEL_FOUR: op_b = 32'd4;
            default:    op_b = i_rs2_data;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb
    begin
        case (i_ctrl.alu_op)
            ALU_SUB:  o_result = op_a - op_b;
            ALU_SLL:  o_result = op_a << shamt;
            ALU_SLT:  o_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: o_result = {31'b0, op_a < op_b};
            ALU_XOR:  o_result = op_a ^ op_b;
            ALU_SRL:  o_result = op_a >> shamt;
            ALU_SRA:  o_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   o_result = op_a | op_b;
            ALU_AND:  o_result = op_a & op_b;
            default:  o_result = op_a + op_b;
        endcase
    end

    // Branch flags always compare the raw register operands
    assign o_is_equal         = (i_rs1_data == i_rs2_data);
    assign o_is_less_signed   = ($signed(i_rs1_data) < $signed(i_rs2_data));
    assign o_is_less_unsigned = (i_rs1_data < i_rs2_data);

endmodule

/* design/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen
    import core_pkg::*;
(
    input  inst_t           i_inst,
    output logic [XLEN-1:0] o_imm
);

    logic sign;

    assign sign = i_inst[31];

    always_comb
    begin
        case (opcode_e'(i_inst[6:0]))
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:                                   // I type
                o_imm = {{20{sign}}, i_inst[31:20]};
            OPC_STORE:                                                        // S type
                o_imm = {{20{sign}}, i_inst[31:25], i_inst[11:7]};
            OPC_BRANCH:                                                       // B type
                o_imm = {{19{sign}}, sign, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:                                               // U type
                o_imm = {i_inst[31:12], 12'b0};
            OPC_JAL:                                                          // J type
                o_imm = {{11{sign}}, sign, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
            default:
                o_imm = '0;
        endcase
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/10ps

module reg_file
    import core_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic [4:0]      i_rs1_addr,
    input  logic [4:0]      i_rs2_addr,
    input  logic [4:0]      i_rd_addr,
    input  logic            i_wr_en,
    input  logic [XLEN-1:0] i_wr_data,
    output logic [XLEN-1:0] o_rs1_data,
    output logic [XLEN-1:0] o_rs2_data
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_wr_en && i_rd_addr != 5'd0) // x0 stays zero
            regs[i_rd_addr] <= i_wr_data;
    end

    assign o_rs1_data = regs[i_rs1_addr];
    assign o_rs2_data = regs[i_rs2_addr];

endmodule

/* design/pc_unit.sv */
`timescale 1ns/10ps

module pc_unit
    import core_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  pc_next_sel_e    i_sel,
    input  logic [XLEN-1:0] i_imm,
    input  logic [XLEN-1:0] i_target, // Base register for indirect jumps
    output logic [XLEN-1:0] o_pc
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jump_base;
    logic [XLEN-1:0] jump_addr;
    logic [XLEN-1:0] pc_next;

    assign pc_plus4  = pc_q + 32'd4;
    assign jump_base = (i_sel == PC_INDIRECT) ? i_target : pc_q;
    assign jump_addr = jump_base + i_imm;

    always_comb
    begin
        case (i_sel)
            PC_OFFSET:   pc_next = jump_addr;
            PC_INDIRECT: pc_next = {jump_addr[XLEN-1:1], 1'b0}; // JALR clears bit 0
            default:     pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            pc_q <= RESET_PC;
        else
            pc_q <= pc_next;
    end

    assign o_pc = pc_q;

endmodule

/* design/lsu.sv */
`timescale 1ns/10ps

module lsu
    import core_pkg::*;
(
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_addr,       // Effective address from ALU
    input  logic [XLEN-1:0] i_store_data,
    input  logic [XLEN-1:0] i_dmem_rdata,
    output dmem_req_t       o_dmem_req,
    output logic [XLEN-1:0] o_load_data
);

    logic [1:0]      lane;
    logic [XLEN-1:0] rdata_shifted;

    assign lane = i_addr[1:0];

    always_comb
    begin
        o_dmem_req.addr  = {i_addr[XLEN-1:2], 2'b00};
        o_dmem_req.wr_en = i_ctrl.mem_wr_en;
        o_dmem_req.rd_en = i_ctrl.mem_rd_en;
        case (i_ctrl.mem_access)
            ACCESS_BYTE:
            begin
                o_dmem_req.wdata   = {4{i_store_data[7:0]}};
                o_dmem_req.byte_en = 4'b0001 << lane;
            end
            ACCESS_HALF:
            begin
                o_dmem_req.wdata   = {2{i_store_data[15:0]}};
                o_dmem_req.byte_en = 4'b0011 << {lane[1], 1'b0}; // Lower or upper half
            end
            default:
            begin
                o_dmem_req.wdata   = i_store_data;
                o_dmem_req.byte_en = 4'b1111;
            end
        endcase
    end

    // Bring addressed lane down to bit 0
    assign rdata_shifted = i_dmem_rdata >> {lane, 3'b000};

    always_comb
    begin
        case (i_ctrl.mem_access)
            ACCESS_BYTE:
                o_load_data = {{24{rdata_shifted[7] & ~i_ctrl.mem_unsigned}},
                               rdata_shifted[7:0]};
            ACCESS_HALF:
                o_load_data = {{16{rdata_shifted[15] & ~i_ctrl.mem_unsigned}},
                               rdata_shifted[15:0]};
            default:
                o_load_data = i_dmem_rdata;
        endcase
    end

endmodule

/* design/core_top.sv */
`timescale 1ns/10ps

module core_top
    import core_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    output logic [XLEN-1:0] o_imem_addr,
    input  inst_t           i_imem_data,
    output dmem_req_t       o_dmem_req,
    input  logic [XLEN-1:0] i_dmem_rdata
);

    ctrl_t           ctrl;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] rd_data;
    logic            is_equal;
    logic            is_less_signed;
    logic            is_less_unsigned;

    assign o_imem_addr = pc;
    assign rd_data     = (ctrl.wr_data_sel == WR_SEL_LOAD) ? load_data : alu_result;

    datapath_controller ctrl_i (
        .i_inst             (i_imem_data),
        .i_is_equal         (is_equal),
        .i_is_less_signed   (is_less_signed),
        .i_is_less_unsigned (is_less_unsigned),
        .o_ctrl             (ctrl)
    );

    imm_gen imm_i (
        .i_inst (i_imem_data),
        .o_imm  (imm)
    );

    reg_file regs_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (i_imem_data[19:15]),
        .i_rs2_addr (i_imem_data[24:20]),
        .i_rd_addr  (i_imem_data[11:7]),
        .i_wr_en    (ctrl.reg_wr_en),
        .i_wr_data  (rd_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    exec_unit exec_i (
        .i_ctrl             (ctrl),
        .i_pc               (pc),
        .i_rs1_data         (rs1_data),
        .i_rs2_data         (rs2_data),
        .i_imm              (imm),
        .o_result           (alu_result),
        .o_is_equal         (is_equal),
        .o_is_less_signed   (is_less_signed),
        .o_is_less_unsigned (is_less_unsigned)
    );

    lsu lsu_i (
        .i_ctrl       (ctrl),
        .i_addr       (alu_result),
        .i_store_data (rs2_data),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_req   (o_dmem_req),
        .o_load_data  (load_data)
    );

    // The PC adder forms the JALR target rs1 + imm
    pc_unit pc_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_sel    (ctrl.pc_next_sel),
        .i_imm    (imm),
        .i_target (rs1_data),
        .o_pc     (pc)
    );

endmodule

/* verification/core_tb.sv */
`timescale 1ns/10ps

module core_tb
    import core_pkg::*;
;

    localparam int          MAX_CYCLES = 2000;
    localparam logic [31:0] DATA_BASE  = 32'h0000_1000;

    logic            i_clk;
    logic            i_rst_n;
    logic [XLEN-1:0] o_imem_addr;
    inst_t           i_imem_data;
    dmem_req_t       o_dmem_req;
    logic [XLEN-1:0] i_dmem_rdata;

    logic [31:0] prog  [256];
    logic [31:0] dmem  [64];  // Memory seen by the DUT
    logic [31:0] mmem  [64];  // Mirror memory of the ISA model
    logic [31:0] mregs [32];  // Mirror register file
    logic [31:0] lfsr;
    logic [31:0] ref_pc;
    logic [31:0] end_pc;
    int          gen_len;
    logic        go;
    logic        done;

    core_top dut_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_dmem_req   (o_dmem_req),
        .i_dmem_rdata (i_dmem_rdata)
    );

    function automatic logic [31:0] fetch(input logic [31:0] pc);
        return (pc < 32'd1024) ? prog[pc[9:2]] : NOP_INST; // NOP past the program
    endfunction

    assign i_imem_data  = fetch(o_imem_addr);
    assign i_dmem_rdata = dmem[o_dmem_req.addr[7:2]];

    always @(posedge i_clk)
    begin
        if (i_rst_n && o_dmem_req.wr_en)
        begin
            for (int l = 0; l < 4; l++)
                if (o_dmem_req.byte_en[l])
                    dmem[o_dmem_req.addr[7:2]][8*l +: 8] <= o_dmem_req.wdata[8*l +: 8];
        end
    end

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd, op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] inst);
        prog[gen_len] = inst;
        gen_len++;
    endtask

    // Store a register to a random data word off base x31
    task automatic store_reg(input logic [31:0] r);
        emit(enc_s(rnd(6) * 4, r, 32'd31, 32'd2));
    endtask

    task automatic gen_program();
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] f3;
        logic [31:0] imm;
        logic [31:0] sz;
        gen_len = 0;
        for (int i = 0; i < 256; i++)
            prog[i] = NOP_INST;
        emit({20'h00001, 5'd31, 7'h37}); // LUI x31 with DATA_BASE
        for (int r = 1; r < 31; r++)
        begin
            emit({20'(rnd(20)), r[4:0], 7'h37});
            emit(enc_i(rnd(12), r, 32'd0, r, 32'h13));
        end
        while (gen_len < 236)
        begin
            rd  = rnd(5) % 31;
            rs1 = rnd(5);
            rs2 = rnd(5);
            f3  = rnd(3);
            case (rnd(4) % 10)
                0:
                begin
                    imm = (f3 == 0 || f3 == 5) ? rnd(1) << 5 : 32'd0; // SUB or SRA
                    emit(enc_r(imm, rs2, rs1, f3, rd, 32'h33));
                    store_reg(rd);
                end
                1:
                begin
                    if (f3 == 1)
                        imm = rnd(5);
                    else if (f3 == 5)
                        imm = (rnd(1) << 10) | rnd(5);
                    else
                        imm = rnd(12);
                    emit(enc_i(imm, rs1, f3, rd, 32'h13));
                    store_reg(rd);
                end
                2:
                begin
                    emit({20'(rnd(20)), rd[4:0], rnd(1) ? 7'h37 : 7'h17}); // LUI or AUIPC
                    store_reg(rd);
                end
                3:
                begin
                    emit(enc_j(32'd8, rd));
                    emit(rnd(32)); // Skipped
                    store_reg(rd);
                end
                4:
                begin
                    emit({20'h0, 5'd5, 7'h17});
                    emit(enc_i(32'd13, 32'd5, 32'd0, rd, 32'h67)); // Odd offset lands at +12
                    emit(rnd(32));
                    store_reg(rd);
                end
                5:
                begin
                    if (f3 == 2 || f3 == 3)
                        f3 = f3 + 4;
                    if (rnd(1) == 1)
                        rs2 = rs1; // Equal operands
                    emit(enc_b(32'd8, rs2, rs1, f3));
                    emit(enc_i(32'd1, 32'd7, 32'd0, 32'd7, 32'h13));
                    store_reg(32'd7);
                end
                6:
                begin
                    sz  = rnd(2) % 3;
                    imm = (sz == 0) ? rnd(8) : (sz == 1) ? rnd(7) * 2 : rnd(6) * 4;
                    emit(enc_s(imm, rs2, 32'd31, sz));
                end
                7:
                begin
                    sz  = rnd(2) % 3;
                    imm = (sz == 0) ? rnd(8) : (sz == 1) ? rnd(7) * 2 : rnd(6) * 4;
                    f3  = (sz != 2 && rnd(1) == 1) ? sz + 4 : sz; // LBU LHU
                    emit(enc_i(imm, 32'd31, f3, rd, 32'h03));
                    store_reg(rd);
                end
                8:
                    emit({25'(rnd(25)), 7'b0001011}); // Unknown opcode
                default:
                begin
                    emit(enc_i(rnd(12), rs1, 32'd0, 32'd0, 32'h13)); // Write to x0
                    store_reg(32'd0);
                end
            endcase
        end
        end_pc = gen_len * 4;
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return {31'b0, $signed(x) < $signed(y)};
            3'd3:    return {31'b0, x < y};
            3'd4:    return x ^ y;
            3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    // ISA model of one instruction on the mirror state
    function automatic dmem_req_t iss_step(input logic [31:0] inst, input logic [31:0] pc,
                                           output logic [31:0] next_pc);
        dmem_req_t   req;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] addr;
        logic [31:0] sh;
        logic [31:0] val;
        logic        wb;
        logic        cond;
        f3      = inst[14:12];
        a       = mregs[inst[19:15]];
        b       = mregs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        req     = '0;
        next_pc = pc + 32'd4;
        wb      = 1'b0;
        val     = '0;
        case (inst[6:0])
            7'h37:
            begin
                wb  = 1'b1;
                val = {inst[31:12], 12'b0};
            end
            7'h17:
            begin
                wb  = 1'b1;
                val = pc + {inst[31:12], 12'b0};
            end
            7'h6f:
            begin
                wb      = 1'b1;
                val     = pc + 32'd4;
                next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            7'h67:
            begin
                if (f3 == 3'd0)
                begin
                    wb      = 1'b1;
                    val     = pc + 32'd4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
            end
            7'h63:
            begin
                case (f3)
                    3'd0:    cond = (a == b);
                    3'd1:    cond = (a != b);
                    3'd4:    cond = ($signed(a) < $signed(b));
                    3'd5:    cond = ($signed(a) >= $signed(b));
                    3'd6:    cond = (a < b);
                    3'd7:    cond = (a >= b);
                    default: cond = 1'b0;
                endcase
                if (cond)
                    next_pc = pc + imm_b;
            end
            7'h03:
            begin
                if (f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7)
                begin
                    addr       = a + imm_i;
                    req.rd_en  = 1'b1;
                    req.addr   = addr & ~32'd3;
                    sh         = mmem[addr[7:2]] >> {addr[1:0], 3'b000};
                    wb         = 1'b1;
                    case (f3)
                        3'd0:    val = {{24{sh[7]}}, sh[7:0]};
                        3'd1:    val = {{16{sh[15]}}, sh[15:0]};
                        3'd4:    val = {24'b0, sh[7:0]};
                        3'd5:    val = {16'b0, sh[15:0]};
                        default: val = sh;
                    endcase
                end
            end
            7'h23:
            begin
                if (f3 < 3'd3)
                begin
                    addr      = a + imm_s;
                    req.wr_en = 1'b1;
                    req.addr  = addr & ~32'd3;
                    case (f3)
                        3'd0:
                        begin
                            req.wdata   = {4{b[7:0]}};
                            req.byte_en = 4'b0001 << addr[1:0];
                        end
                        3'd1:
                        begin
                            req.wdata   = {2{b[15:0]}};
                            req.byte_en = 4'b0011 << addr[1:0];
                        end
                        default:
                        begin
                            req.wdata   = b;
                            req.byte_en = 4'b1111;
                        end
                    endcase
                    for (int l = 0; l < 4; l++)
                        if (req.byte_en[l])
                            mmem[addr[7:2]][8*l +: 8] = req.wdata[8*l +: 8];
                end
            end
            7'h13:
            begin
                wb  = 1'b1;
                val = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
            end
            7'h33:
            begin
                if (inst[31:25] == 7'h00 ||
                    (inst[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                begin
                    wb  = 1'b1;
                    val = alu_ref(f3, inst[30], a, b);
                end
            end
            default: ;
        endcase
        if (wb && inst[11:7] != 5'd0)
            mregs[inst[11:7]] = val;
        return req;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act)
        begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "Stopping at first error");
        end
    endtask

    // Compare process
    initial
    begin
        dmem_req_t   exp;
        logic [31:0] nxt;
        for (int t = 0; t < 100 && go !== 1'b1; t++)
            @(posedge i_clk);
        if (go !== 1'b1)
        begin
            $display("Errors found");
            $fatal(1, "Reset was never released");
        end
        for (int cyc = 0; cyc < MAX_CYCLES && !done; cyc++)
        begin
            @(negedge i_clk);
            check_value("pc", ref_pc, o_imem_addr);
            if (ref_pc == end_pc)
                done = 1'b1;
            else
            begin
                exp = iss_step(fetch(ref_pc), ref_pc, nxt);
                check_value("wr_en", 32'(exp.wr_en), 32'(o_dmem_req.wr_en));
                check_value("rd_en", 32'(exp.rd_en), 32'(o_dmem_req.rd_en));
                if (exp.wr_en || exp.rd_en)
                    check_value("addr", exp.addr, o_dmem_req.addr);
                if (exp.wr_en)
                begin
                    check_value("byte_en", 32'(exp.byte_en), 32'(o_dmem_req.byte_en));
                    check_value("wdata", exp.wdata, o_dmem_req.wdata);
                end
                ref_pc = nxt;
            end
        end
    end

    initial
    begin
        i_rst_n = 1'b0;
        go      = 1'b0;
        done    = 1'b0;
        lfsr    = 32'd78;
        ref_pc  = RESET_PC;
        for (int i = 0; i < 64; i++)
        begin
            mmem[i] = (32'h9E37_79B9 * (i + 1)) ^ (DATA_BASE + i * 4);
            dmem[i] <= mmem[i];
        end
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        gen_program();
        repeat (9) @(negedge i_clk);
        go = 1'b1;
        @(negedge i_clk);
        i_rst_n = 1'b1;
        for (int t = 0; t < MAX_CYCLES && !done; t++)
            @(negedge i_clk);
        if (!done)
        begin
            $display("Errors found");
            $fatal(1, "Timeout before the program end was reached");
        end
        else
        begin
            for (int i = 0; i < 64; i++)
                check_value($sformatf("mem[%0d]", i), mmem[i], dmem[i]);
            $display("No errors");
            $finish;
        end
    end

endmodule

/* list.f */
common/core_pkg.sv
design/datapath_controller.sv
design/exec_unit.sv
design/imm_gen.sv
design/reg_file.sv
design/pc_unit.sv
design/lsu.sv
design/core_top.sv
verification/core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f list.f --top-module core_tb -o core_sim; then
    echo "Build failed"
    exit 1
fi

if ! ./obj_dir/core_sim; then
    echo "Simulation failed"
    exit 1
fi

exit 0
